//--- rtl/cachePkg.sv
package cachePkg;

    typedef logic [63:0] addrT;
    typedef logic [60:0] lineAddrT; // address bits 63:3, tag and memory address
    typedef logic [63:0] wordT;
    typedef logic [7:0]  maskT;
    typedef logic [2:0]  offsetT;

    typedef enum logic [1:0] {
        SZ_BYTE   = 2'd0,
        SZ_HALF   = 2'd1,
        SZ_WORD   = 2'd2,
        SZ_DOUBLE = 2'd3
    } accSizeT;

    // decoded request, held for the whole transaction
    typedef struct packed {
        logic     isStore;
        logic     isSigned;
        accSizeT  size;
        lineAddrT line;
        offsetT   offset;
        maskT     storeMask;   // already shifted to offset
        wordT     storeData;   // moved to its byte lanes
    } reqT;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        LOOKUP  = 2'd1,
        REFILL  = 2'd2,
        RESPOND = 2'd3
    } missStateT;

endpackage

//--- rtl/requestDecode.sv
`timescale 1ns/1ns

module requestDecode import cachePkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    reqValid,
    input  logic    reqStore,
    input  logic    reqSigned,
    input  accSizeT reqSize,
    input  addrT    reqAddr,
    input  wordT    reqData,
    input  logic    busy,
    output reqT     req,
    output logic    accepted
);

    logic   take;
    offsetT offset;
    maskT   baseMask;

    assign take   = reqValid && !busy; // strobes while busy are dropped
    assign offset = reqAddr[2:0];

    always_comb begin
        case (reqSize)
            SZ_BYTE: baseMask = 8'h01;
            SZ_HALF: baseMask = 8'h03;
            SZ_WORD: baseMask = 8'h0f;
            default: baseMask = 8'hff;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            accepted <= 1'b0;
        end else begin
            accepted <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req.isStore   <= reqStore;
            req.isSigned  <= reqSigned;
            req.size      <= reqSize;
            req.line      <= reqAddr[63:3];
            req.offset    <= offset;
            req.storeMask <= baseMask << offset;
            req.storeData <= reqData << {offset, 3'b000}; // into byte lanes
        end
    end

endmodule

//--- rtl/cacheArray.sv
`timescale 1ns/1ns

module cacheArray import cachePkg::*; #(
    parameter int SETS = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  lineAddrT line,
    output logic     hit,
    output wordT     hitData,
    input  logic     storeWrite,
    input  maskT     storeMask,
    input  wordT     storeData,
    input  logic     refill,
    input  wordT     refillData
);

    localparam int indexBits = $clog2(SETS);

    logic [indexBits-1:0] idx;

    // two ways, full line address kept as tag
    logic     valid  [2][SETS];
    lineAddrT tags   [2][SETS];
    wordT     data   [2][SETS];
    logic     victim [SETS];   // set means way 0 is next victim

    logic [1:0] wayHit;
    logic       victimWay;

    assign idx = line[indexBits-1:0];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wayHit[w] = valid[w][idx] && (tags[w][idx] == line);
        end
    end

    assign hit       = |wayHit;
    assign hitData   = wayHit[1] ? data[1][idx] : data[0][idx];
    assign victimWay = ~victim[idx];

    // valid and victim bits
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid[0][s] <= 1'b0;
                valid[1][s] <= 1'b0;
                victim[s]   <= 1'b0; // way 1 filled first
            end
        end else if (refill) begin
            valid[victimWay][idx] <= 1'b1;
            victim[idx]           <= ~victim[idx];
        end
    end

    // tag and data storage
    always_ff @(posedge clk) begin
        if (refill) begin
            tags[victimWay][idx] <= line;
            data[victimWay][idx] <= refillData;
        end else if (storeWrite) begin
            // merge into the hitting way only, a miss leaves the array alone
            for (int w = 0; w < 2; w++) begin
                if (wayHit[w]) begin
                    for (int b = 0; b < 8; b++) begin
                        if (storeMask[b]) begin
                            data[w][idx][8*b +: 8] <= storeData[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

//--- rtl/missHandler.sv
`timescale 1ns/1ns

module missHandler import cachePkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     accepted,
    input  reqT      req,
    input  logic     hit,
    input  logic     memRValid,
    output logic     busy,
    output logic     storeWrite,
    output logic     refill,
    output logic     respond,
    output logic     memRead,
    output logic     memWrite,
    output lineAddrT memAddr,
    output wordT     memWData,
    output maskT     memWMask
);

    missStateT state;
    missStateT nextState;
    logic      filled;   // refill written, one cycle before RESPOND

    always_ff @(posedge clk) begin
        if (!rst) begin
            state  <= IDLE;
            filled <= 1'b0;
        end else begin
            state  <= nextState;
            filled <= (state == REFILL) && memRValid;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            IDLE:    if (accepted) nextState = LOOKUP;
            LOOKUP:  nextState = (!req.isStore && !hit) ? REFILL : IDLE;
            REFILL:  if (filled) nextState = RESPOND;
            default: nextState = IDLE;
        endcase
    end

    assign busy = accepted || (state != IDLE);

    assign storeWrite = (state == LOOKUP) && req.isStore;
    assign memWrite   = storeWrite;  // write-through, hit or miss
    assign memRead    = (state == LOOKUP) && !req.isStore && !hit;
    assign refill     = (state == REFILL) && memRValid;

    // loads in RESPOND hit the freshly refilled way
    assign respond = ((state == LOOKUP) && (req.isStore || hit)) || (state == RESPOND);

    assign memAddr  = req.line;
    assign memWData = req.storeData;
    assign memWMask = req.storeMask;

endmodule

//--- rtl/loadAlign.sv
`timescale 1ns/1ns

module loadAlign import cachePkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic respond,
    input  reqT  req,
    input  wordT hitData,
    output logic rspValid,
    output wordT rspData
);

    wordT shifted;
    wordT aligned;

    function automatic wordT extend(wordT v, accSizeT size, logic sgn);
        wordT r;
        case (size)
            SZ_BYTE: r = {{56{sgn & v[7]}}, v[7:0]};
            SZ_HALF: r = {{48{sgn & v[15]}}, v[15:0]};
            SZ_WORD: r = {{32{sgn & v[31]}}, v[31:0]};
            default: r = v;
        endcase
        return r;
    endfunction

    assign shifted = hitData >> {req.offset, 3'b000};
    assign aligned = extend(shifted, req.size, req.isSigned);

    always_ff @(posedge clk) begin
        if (!rst) begin
            rspValid <= 1'b0;
        end else begin
            rspValid <= respond;
        end
    end

    always_ff @(posedge clk) begin
        if (respond) begin
            rspData <= req.isStore ? '0 : aligned; // stores answer zero
        end
    end

endmodule

//--- rtl/dataCacheTop.sv
`timescale 1ns/1ns

module dataCacheTop import cachePkg::*; #(
    parameter int SETS = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     reqValid,
    input  logic     reqStore,
    input  logic     reqSigned,
    input  accSizeT  reqSize,
    input  addrT     reqAddr,
    input  wordT     reqData,
    output logic     busy,
    output logic     rspValid,
    output wordT     rspData,
    output logic     memRead,
    output lineAddrT memAddr,
    input  wordT     memRData,
    input  logic     memRValid,
    output logic     memWrite,
    output wordT     memWData,
    output maskT     memWMask
);

    reqT  req;
    logic accepted;
    logic hit;
    wordT hitData;
    logic storeWrite;
    logic refill;
    logic respond;

    requestDecode decode (
        .clk(clk), .rst(rst),
        .reqValid(reqValid), .reqStore(reqStore), .reqSigned(reqSigned),
        .reqSize(reqSize), .reqAddr(reqAddr), .reqData(reqData),
        .busy(busy), .req(req), .accepted(accepted)
    );

    cacheArray #(.SETS(SETS)) array (
        .clk(clk), .rst(rst), .line(req.line), .hit(hit), .hitData(hitData),
        .storeWrite(storeWrite), .storeMask(req.storeMask), .storeData(req.storeData),
        .refill(refill), .refillData(memRData)  // refill straight from memory
    );

    missHandler handler (
        .clk(clk), .rst(rst), .accepted(accepted), .req(req), .hit(hit),
        .memRValid(memRValid), .busy(busy), .storeWrite(storeWrite),
        .refill(refill), .respond(respond), .memRead(memRead), .memWrite(memWrite),
        .memAddr(memAddr), .memWData(memWData), .memWMask(memWMask)
    );

    loadAlign align (
        .clk(clk), .rst(rst), .respond(respond), .req(req), .hitData(hitData),
        .rspValid(rspValid), .rspData(rspData)
    );

endmodule

//--- verification/cacheChecker.sv
`timescale 1ns/1ns

module cacheChecker import cachePkg::*; #(
    parameter int SETS = 4
) (
    input logic     clk,
    input logic     rst,
    input logic     reqValid,
    input logic     reqStore,
    input logic     reqSigned,
    input accSizeT  reqSize,
    input addrT     reqAddr,
    input wordT     reqData,
    input logic     busy,
    input logic     rspValid,
    input wordT     rspData,
    input logic     memRead,
    input lineAddrT memAddr,
    input logic     memWrite,
    input wordT     memWData,
    input maskT     memWMask
);

    localparam int IDXW = $clog2(SETS);

    string    testName = "none";
    logic     wantMiss = 1'b0;   // miss expected by the stimulus table
    int       errors = 0;

    wordT     refMem [lineAddrT];
    lineAddrT resTag [2][SETS];
    logic     resValid [2][SETS];
    logic     resVictim [SETS];  // set means way 0 refills next

    logic            pending = 1'b0;
    logic            isStore, predMiss, sawRead, sawWrite, way;
    lineAddrT        curLine;
    logic [IDXW-1:0] idx;
    maskT            expMask;
    wordT            expWData, lanes, expRsp, merged;
    int              age;

    function automatic wordT lineValue(lineAddrT l);
        if (refMem.exists(l)) begin
            return refMem[l];
        end
        return {3'b000, l} ^ 64'hA5A5_0000_5A5A_FFFF;
    endfunction

    // pick the addressed bytes, then extend by the load rule
    function automatic wordT expectLoad(wordT w, offsetT off, accSizeT size, logic sgn);
        int   bits;
        wordT keep;
        wordT v;
        bits = 8 << size;
        keep = (bits == 64) ? '1 : ((64'd1 << bits) - 64'd1);
        v    = (w >> (8 * off)) & keep;
        if (sgn && bits < 64 && v[bits-1]) begin
            v = v | ~keep;
        end
        return v;
    endfunction

    task automatic complain(string what);
        $display("%s: %s", testName, what);
        errors++;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            pending = 1'b0;
            for (int s = 0; s < SETS; s++) begin
                resValid[0][s] = 1'b0;
                resValid[1][s] = 1'b0;
                resVictim[s]   = 1'b0;
            end
        end else begin
            if (pending) age++;
            if ((rspValid || memRead || memWrite) && !pending) begin
                complain("output pulse with no request in flight");
            end
            // busy high from N+1, low again together with rspValid
            if (pending && age >= 1 && busy == rspValid) begin
                complain("busy level wrong while a request is in flight");
            end
            if (memRead && pending) begin
                sawRead = 1'b1;
                if (!predMiss || age != 2) complain("memRead not expected in this cycle");
                if (memAddr != curLine) begin
                    $display("FAILED %s: memAddr expected %h, got %h", testName, curLine, memAddr);
                    errors++;
                end
            end
            if (memWrite && pending) begin
                sawWrite = 1'b1;
                if (!isStore || age != 2) complain("memWrite not expected in this cycle");
                if (memWMask != expMask || (memWData & lanes) != (expWData & lanes)) begin
                    $display("FAILED %s: write expected %h/%h, got %h/%h", testName,
                             expMask, expWData & lanes, memWMask, memWData & lanes);
                    errors++;
                end
            end
            if (rspValid && pending) begin
                if (sawRead != predMiss || sawWrite != isStore) begin
                    complain("memory traffic differs from the residency model");
                end
                if (!predMiss && age != 3) complain("hit or store did not answer in 3 cycles");
                if (rspData != expRsp) begin
                    $display("FAILED %s: rspData expected %h, got %h", testName, expRsp, rspData);
                    errors++;
                end
                pending = 1'b0;
            end
            if (reqValid && !busy) begin
                pending  = 1'b1;
                age      = 0;
                sawRead  = 1'b0;
                sawWrite = 1'b0;
                isStore  = reqStore;
                curLine  = reqAddr[63:3];
                idx      = curLine[IDXW-1:0];
                expMask  = 8'(((1 << (1 << reqSize)) - 1) << reqAddr[2:0]);
                expWData = reqData << (8 * reqAddr[2:0]);
                for (int b = 0; b < 8; b++) begin
                    lanes[8*b +: 8] = {8{expMask[b]}};
                end
                predMiss = !reqStore &&
                           !((resValid[0][idx] && resTag[0][idx] == curLine) ||
                             (resValid[1][idx] && resTag[1][idx] == curLine));
                if (predMiss != wantMiss) complain("stimulus table and residency model disagree");
                if (predMiss) begin
                    way                = !resVictim[idx];
                    resTag[way][idx]   = curLine;
                    resValid[way][idx] = 1'b1;
                    resVictim[idx]     = !resVictim[idx];
                end
                expRsp = reqStore ? '0 :
                         expectLoad(lineValue(curLine), reqAddr[2:0], reqSize, reqSigned);
                if (reqStore) begin  // write-through, memory always takes the bytes
                    merged = (lineValue(curLine) & ~lanes) | (expWData & lanes);
                    refMem[curLine] = merged;
                end
            end
        end
    end

endmodule

//--- verification/dataCache_assertions.sv
`timescale 1ns/1ns

module dataCacheAssertions (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic rspValid,
    input logic memRead,
    input logic memWrite,
    input logic memRValid
);

    int   failures = 0;
    logic inReset = 1'b0;  // reset seen on the previous edge

    always @(posedge clk) begin
        inReset <= !rst;
    end

    task automatic countFailure(string what);
        failures++;
        $error("%s", what);
    endtask

    readWriteApart: assert property (@(posedge clk) disable iff (!rst) !(memRead && memWrite))
        else countFailure("memRead and memWrite fired together");
    rspInsideBusy: assert property (@(posedge clk) disable iff (!rst)
        rspValid |-> (busy || $past(busy)))
        else countFailure("rspValid outside a busy window");
    quietInReset: assert property (@(posedge clk)
        (inReset && !rst) |-> !(busy || rspValid || memRead || memWrite))
        else countFailure("output active during reset");
    refillAnswers: assert property (@(posedge clk) disable iff (!rst) memRValid |-> ##3 rspValid)
        else countFailure("no rspValid three cycles after memRValid");

endmodule

bind dataCacheTop dataCacheAssertions protocolChecks (
    .clk(clk), .rst(rst), .busy(busy), .rspValid(rspValid),
    .memRead(memRead), .memWrite(memWrite), .memRValid(memRValid)
);

//--- verification/dataCacheTb.sv
`timescale 1ns/1ns

module dataCacheTb import cachePkg::*; ();

    typedef struct packed {
        logic    isStore;
        logic    isSigned;
        accSizeT size;
        addrT    addr;
        wordT    data;
        logic    miss;     // memRead expected
    } stimT;

    localparam int SETS = 4;
    localparam int WAIT_LIMIT = 60;

    logic     clk, rst, reqValid, reqStore, reqSigned;
    accSizeT  reqSize;
    addrT     reqAddr;
    wordT     reqData;
    logic     busy, rspValid, memRead, memWrite;
    wordT     rspData, memWData;
    lineAddrT memAddr;
    maskT     memWMask;
    logic     memRValid = 1'b0;
    wordT     memRData = '0;

    string    names[$];
    stimT     tests[$];
    int       timeouts = 0;
    int       seed = 32'h6d0a_1dc4;
    wordT     memModel [lineAddrT];
    logic     readPending = 1'b0;
    lineAddrT readLine;
    int       readDelay;

    dataCacheTop #(.SETS(SETS)) uut (.*);
    cacheChecker #(.SETS(SETS)) chk (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic wordT memValue(lineAddrT l);
        if (memModel.exists(l)) begin
            return memModel[l];
        end
        return {3'b000, l} ^ 64'hA5A5_0000_5A5A_FFFF;  // unwritten lines
    endfunction

    // memory: masked writes, reads answered after 2 to 6 cycles
    always @(posedge clk) begin
        wordT w;
        memRValid <= 1'b0;
        if (rst && memWrite) begin
            w = memValue(memAddr);
            for (int b = 0; b < 8; b++) begin
                if (memWMask[b]) w[8*b +: 8] = memWData[8*b +: 8];
            end
            memModel[memAddr] = w;
        end
        if (rst && memRead) begin
            readPending = 1'b1;
            readLine    = memAddr;
            readDelay   = 1 + int'($unsigned($random(seed)) % 5);
        end else if (readPending) begin
            readDelay--;
            if (readDelay == 0) begin
                memRValid   <= 1'b1;
                memRData    <= memValue(readLine);
                readPending = 1'b0;
            end
        end
    end

    task automatic addTest(string name, logic st, logic sg, accSizeT sz, addrT a, wordT d,
                           logic miss);
        names.push_back(name);
        tests.push_back({st, sg, sz, a, d, miss});
    endtask

    task automatic waitIdle(string name);
        int n;
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (busy) begin
            $display("timeout: cache still busy before %s", name);
            timeouts++;
        end
    endtask

    task automatic waitResponse(string name);
        int n;
        n = 0;
        @(posedge clk);
        while (!rspValid && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!rspValid) begin
            $display("timeout: no response for %s", name);
            timeouts++;
        end
    endtask

    initial begin
        int failures;
        rst       = 1'b0;
        reqValid  = 1'b0;
        reqStore  = 1'b0;
        reqSigned = 1'b0;
        reqSize   = SZ_DOUBLE;
        reqAddr   = '0;
        reqData   = '0;
        addTest("first load miss",       0, 0, SZ_DOUBLE, 64'h1000, 0, 1);
        addTest("reload same line",      0, 0, SZ_DOUBLE, 64'h1000, 0, 0);
        addTest("lb signed off7",        0, 1, SZ_BYTE,   64'h1007, 0, 0);
        addTest("lbu off7",              0, 0, SZ_BYTE,   64'h1007, 0, 0);
        addTest("lb signed off2",        0, 1, SZ_BYTE,   64'h1002, 0, 0);
        addTest("lh signed off6",        0, 1, SZ_HALF,   64'h1006, 0, 0);
        addTest("lhu off6",              0, 0, SZ_HALF,   64'h1006, 0, 0);
        addTest("lw signed off4",        0, 1, SZ_WORD,   64'h1004, 0, 0);
        addTest("lwu off4",              0, 0, SZ_WORD,   64'h1004, 0, 0);
        addTest("lw signed off0",        0, 1, SZ_WORD,   64'h1000, 0, 0);
        addTest("store hit half off2",   1, 0, SZ_HALF,   64'h1002, 64'h8001, 0);
        addTest("load after store hit",  0, 0, SZ_DOUBLE, 64'h1000, 0, 0);
        addTest("store hit byte off5",   1, 0, SZ_BYTE,   64'h1005, 64'hc3, 0);
        addTest("lb after byte store",   0, 1, SZ_BYTE,   64'h1005, 0, 0);
        addTest("store miss word off4",  1, 0, SZ_WORD,   64'h2004, 64'h89ab_cdef, 0);
        addTest("load after store miss", 0, 0, SZ_DOUBLE, 64'h2000, 0, 1);
        addTest("replace load A",        0, 0, SZ_DOUBLE, 64'h3010, 0, 1);
        addTest("replace load B",        0, 0, SZ_DOUBLE, 64'h4010, 0, 1);
        addTest("replace load C",        0, 0, SZ_DOUBLE, 64'h5010, 0, 1);
        addTest("reload B hits",         0, 0, SZ_DOUBLE, 64'h4010, 0, 0);
        addTest("reload A misses",       0, 0, SZ_DOUBLE, 64'h3010, 0, 1);
        addTest("reload C hits",         0, 1, SZ_DOUBLE, 64'h5010, 0, 0);
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        for (int i = 0; i < tests.size(); i++) begin
            waitIdle(names[i]);
            if (timeouts != 0) break;
            chk.testName <= names[i];
            chk.wantMiss <= tests[i].miss;
            reqValid  <= 1'b1;
            reqStore  <= tests[i].isStore;
            reqSigned <= tests[i].isSigned;
            reqSize   <= tests[i].size;
            reqAddr   <= tests[i].addr;
            reqData   <= tests[i].data;
            @(posedge clk);
            reqValid  <= 1'b0;  // one-cycle strobe
            waitResponse(names[i]);
            if (timeouts != 0) break;
        end
        repeat (4) @(posedge clk);
        failures = chk.errors + timeouts + uut.protocolChecks.failures;
        $display("checker errors %0d, timeouts %0d, assertion failures %0d",
                 chk.errors, timeouts, uut.protocolChecks.failures);
        if (failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/cachePkg.sv
rtl/requestDecode.sv
rtl/cacheArray.sv
rtl/missHandler.sv
rtl/loadAlign.sv
rtl/dataCacheTop.sv
verification/cacheChecker.sv
verification/dataCache_assertions.sv
verification/dataCacheTb.sv

//--- run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module dataCacheTb \
    -f verilog.f -o simDataCache
./obj_dir/simDataCache +verilator+error+limit+100 | tee sim.log

if grep -qx "Everything OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
